//--- sources.f
rtl/corr_pkg.sv
rtl/result_bus_if.sv
rtl/lag_delay_line.sv
rtl/corr_engine.sv
rtl/result_store.sv
rtl/axil_readout.sv
rtl/correlator_top.sv
bench/correlator_props.sv
bench/correlator_tb.sv

//--- Makefile
OBJ_DIR := obj_dir
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module correlator_tb \
		-f sources.f --Mdir $(OBJ_DIR) -o correlator_sim

run: build
	./$(OBJ_DIR)/correlator_sim | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

lint:
	verilator --lint-only --timing --assert --top-module correlator_tb -f sources.f

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/correlator_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Correlator testbench: random sample windows started over
// AXI4-Lite, with every result checked against a model.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module correlator_tb;
	import corr_pkg::*;

	localparam int unsigned max_cycles = 30000;

	logic intclk;
	logic arst_n;
	sample_t line_in;
	logic sample_valid;
	axi_addr_t awaddr;
	logic awvalid;
	logic awready;
	axi_data_t wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	axi_addr_t araddr;
	logic arvalid;
	logic arready;
	axi_data_t rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	// The reference model keeps the expected counts and the last four valid samples.
	int unsigned exp_cnt [41];
	sample_t past [1:4];
	int unsigned fed;
	int unsigned win_len;
	logic feeding;
	logic active;
	int unsigned cycles;

	correlator_top UUT (.*);

	always #4 intclk = ~intclk;

	always @(posedge intclk) begin
		cycles++;
		if (cycles >= max_cycles)
			stop_with_failure("timeout: the run did not finish within the cycle limit");
	end

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sample stream and model update
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(posedge intclk) begin
		active = feeding;
		if (active && sample_valid && fed < win_len)
			record_sample(line_in);
		#1;
		line_in = 4'($urandom);
		sample_valid = active ? 1'($urandom_range(0, 1)) : 1'b0;
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		stop_with_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, expected));
	endtask

	task automatic record_sample(input sample_t s);
		int unsigned p;
		logic tap;
		exp_cnt[0]++;
		for (int a = 0; a < 4; a++) begin
			for (int k = 1; k <= 4; k++) begin
				if (s[a] == past[k][a])
					exp_cnt[4*a + k]++;
			end
		end
		// Pairs come in the order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3).
		p = 0;
		for (int i = 0; i < 4; i++) begin
			for (int j = i + 1; j < 4; j++) begin
				for (int k = 0; k < 4; k++) begin
					tap = (k == 0) ? s[j] : past[k][j];
					if (s[i] == tap)
						exp_cnt[17 + 4*p + k]++;
				end
				p++;
			end
		end
		for (int k = 4; k > 1; k--)
			past[k] = past[k-1];
		past[1] = s;
		fed++;
	endtask

	task automatic clear_model(input int unsigned len);
		exp_cnt = '{default: 0};
		past = '{default: '0};
		fed = 0;
		win_len = len;
	endtask

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// AXI4-Lite host
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic axi_write(input axi_addr_t addr, input axi_data_t data);
		int unsigned delay;
		delay = $urandom_range(0, 4);
		awaddr = addr;
		wdata = data;
		wstrb = 4'hf;
		awvalid = 1'b1;
		wvalid = 1'b1;
		@(negedge intclk);
		while (!awready)
			@(negedge intclk);
		assert (wready) else stop_with_failure("awready came without wready");
		@(posedge intclk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		repeat (delay) @(negedge intclk);
		@(posedge intclk);
		#1;
		bready = 1'b1;
		@(negedge intclk);
		while (!bvalid)
			@(negedge intclk);
		assert (bresp == 2'b00) else report_mismatch("bresp", 32'(bresp), 32'h0);
		@(posedge intclk);
		#1;
		bready = 1'b0;
	endtask

	task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
		int unsigned delay;
		axi_data_t first;
		delay = $urandom_range(0, 4);
		araddr = addr;
		arvalid = 1'b1;
		@(negedge intclk);
		while (!arready)
			@(negedge intclk);
		@(posedge intclk);
		#1;
		arvalid = 1'b0;
		@(negedge intclk);
		while (!rvalid)
			@(negedge intclk);
		first = rdata;
		repeat (delay) @(negedge intclk);
		@(posedge intclk);
		#1;
		rready = 1'b1;
		@(negedge intclk);
		assert (rvalid) else stop_with_failure("rvalid dropped while rready was low");
		assert (rresp == 2'b00) else report_mismatch("rresp", 32'(rresp), 32'h0);
		assert (rdata == first) else report_mismatch("rdata during stall", rdata, first);
		data = rdata;
		@(posedge intclk);
		#1;
		rready = 1'b0;
	endtask

	task automatic expect_read(input axi_addr_t addr, input axi_data_t expected,
		input string name);
		axi_data_t v;
		axi_read(addr, v);
		assert (v == expected) else report_mismatch(name, v, expected);
	endtask

	task automatic wait_done();
		axi_data_t st;
		do begin
			axi_read(status_addr, st);
		end while (!st[1]);
		assert (st == 32'h2) else report_mismatch("status at done", st, 32'h2);
	endtask

	task automatic run_window(input int unsigned len, input bit retry_start);
		clear_model(len);
		axi_write(ctrl_addr, {1'b1, 15'd0, 16'(len)});
		feeding = 1'b1;
		if (retry_start) begin
			axi_write(ctrl_addr, {1'b1, 15'd0, 16'(len / 2 + 7)});
			expect_read(status_addr, 32'h1, "status while busy");
		end
		wait_done();
		feeding = 1'b0;
		for (int i = 0; i < 41; i++) begin
			expect_read(result_base + axi_addr_t'(4 * i), 32'(exp_cnt[i]),
				$sformatf("rdata of result %0d", i));
		end
	endtask

	initial begin
		void'($urandom(32'h0757_254f));
		intclk = 1'b0;
		arst_n = 1'b0;
		line_in = '0;
		sample_valid = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		feeding = 1'b0;
		active = 1'b0;
		cycles = 0;
		clear_model(0);
		repeat (10) @(posedge intclk);
		#1;
		arst_n = 1'b1;

		expect_read(status_addr, 32'h0, "status after reset");
		expect_read(result_base, 32'h0, "rdata of result 0 after reset");
		expect_read(result_base + 12'd160, 32'h0, "rdata of result 40 after reset");
		expect_read(12'h0fc, 32'h0, "rdata of unmapped 0x0fc");
		expect_read(12'h1a4, 32'h0, "rdata of unmapped 0x1a4");

		for (int w = 0; w < 4; w++)
			run_window($urandom_range(20, 300), 1'b0);
		run_window($urandom_range(100, 300), 1'b1);

		// After a finished window the engine is idle with done set, and a zero
		// length start must leave it that way.
		expect_read(status_addr, 32'h2, "status before a zero length start");
		axi_write(ctrl_addr, 32'h8000_0000);
		expect_read(status_addr, 32'h2, "status after a zero length start");
		expect_read(12'h0f8, 32'h0, "rdata of unmapped 0x0f8");
		run_window($urandom_range(20, 300), 1'b0);

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/correlator_props.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Correlator properties: AXI response holding, result
// store grants and the busy and done flags.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module correlator_props (
	input logic intclk,
	input logic arst_n,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input logic [31:0] rdata,
	input logic gnt_a,
	input logic gnt_b,
	input logic busy,
	input logic done
);

	assert property (@(posedge intclk) disable iff (!arst_n) bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	assert property (@(posedge intclk) disable iff (!arst_n)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else $error("read response changed before rready");

	assert property (@(posedge intclk) disable iff (!arst_n) !(gnt_a && gnt_b))
		else $error("two result store grants in one cycle");

	assert property (@(posedge intclk) disable iff (!arst_n) !(busy && done))
		else $error("busy and done high together");

endmodule

// Unused inputs of each instance are tied low.
bind axil_readout correlator_props axil_props (
	.intclk(intclk), .arst_n(arst_n), .bvalid(bvalid), .bready(bready),
	.rvalid(rvalid), .rready(rready), .rdata(rdata),
	.gnt_a(1'b0), .gnt_b(1'b0), .busy(busy), .done(done)
);

bind result_store correlator_props store_props (
	.intclk(intclk), .arst_n(arst_n), .bvalid(1'b0), .bready(1'b0),
	.rvalid(1'b0), .rready(1'b0), .rdata(32'h0),
	.gnt_a(engine.gnt), .gnt_b(host.gnt), .busy(1'b0), .done(1'b0)
);

`default_nettype wire

//--- rtl/correlator_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One-bit correlator top level with an AXI4-Lite host port.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module correlator_top (
	input logic intclk,
	input logic arst_n,
	input corr_pkg::sample_t line_in,
	input logic sample_valid,
	input corr_pkg::axi_addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input corr_pkg::axi_data_t wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input corr_pkg::axi_addr_t araddr,
	input logic arvalid,
	output logic arready,
	output corr_pkg::axi_data_t rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);
	import corr_pkg::*;

	logic busy;
	logic done;
	logic start;
	count_t integ_len;

	result_bus_if eng_bus ();
	result_bus_if host_bus ();

	corr_engine u_engine (
		.intclk(intclk), .arst_n(arst_n), .line_in(line_in),
		.sample_valid(sample_valid), .start(start), .integ_len(integ_len),
		.busy(busy), .done(done), .store(eng_bus)
	);

	result_store u_store (.intclk(intclk), .arst_n(arst_n), .engine(eng_bus), .host(host_bus));

	axil_readout u_axil (
		.intclk(intclk), .arst_n(arst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.busy(busy), .done(done), .start(start), .integ_len(integ_len),
		.store(host_bus)
	);

endmodule

`default_nettype wire

//--- rtl/axil_readout.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite slave: control and status registers, and reads
// of the result memory through the store.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module axil_readout (
	input logic intclk,
	input logic arst_n,
	input corr_pkg::axi_addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input corr_pkg::axi_data_t wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input corr_pkg::axi_addr_t araddr,
	input logic arvalid,
	output logic arready,
	output corr_pkg::axi_data_t rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	input logic busy,
	input logic done,
	output logic start,
	output corr_pkg::count_t integ_len,
	result_bus_if.requester store
);
	import corr_pkg::*;

	logic wr_fire;
	logic start_ok;
	count_t new_len;
	logic ar_fire;
	logic ar_result;
	axi_addr_t ar_offset;
	logic rd_pending;
	logic rd_local;
	logic rd_status;
	logic rd_req;
	res_addr_t rd_idx;

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write channel
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign wr_fire = awvalid && wvalid && !bvalid;
	assign awready = wr_fire;
	assign wready = wr_fire;
	assign bresp = 2'b00;

	// Length bytes follow the strobes; start lives in the top byte.
	assign new_len = {wstrb[1] ? wdata[15:8] : integ_len[15:8],
		wstrb[0] ? wdata[7:0] : integ_len[7:0]};
	assign start_ok = wr_fire && (awaddr == ctrl_addr) && wstrb[3] && wdata[31] &&
		(new_len != '0) && !busy;

	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			bvalid <= 1'b0;
			start <= 1'b0;
			integ_len <= '0;
		end else begin
			start <= start_ok;
			if (start_ok)
				integ_len <= new_len;
			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read channel
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign ar_fire = arvalid && !rd_pending && !rvalid;
	assign arready = ar_fire;
	assign ar_offset = araddr - result_base;
	assign ar_result = (araddr >= result_base) && (ar_offset < axi_addr_t'(4 * num_results));
	assign rresp = 2'b00;

	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			rd_pending <= 1'b0;
			rd_local <= 1'b0;
			rd_req <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			rd_local <= ar_fire && !ar_result;
			if (ar_fire) begin
				rd_pending <= 1'b1;
				rd_req <= ar_result;
			end else if (store.gnt) begin
				rd_req <= 1'b0;
			end
			if (rd_local || store.rvalid) begin
				rvalid <= 1'b1;
				rd_pending <= 1'b0;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge intclk) begin
		if (ar_fire) begin
			rd_status <= (araddr == status_addr);
			rd_idx <= ar_offset[7:2];
		end
		if (rd_local)
			rdata <= rd_status ? axi_data_t'({done, busy}) : '0;
		else if (store.rvalid)
			rdata <= axi_data_t'(store.rdata);
	end

	assign store.req = rd_req;
	assign store.we = 1'b0;
	assign store.addr = rd_idx;
	assign store.wdata = '0;

endmodule

`default_nettype wire

//--- rtl/result_store.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result store: fixed-priority arbiter in front of the
// result memory, engine first, host second.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module result_store (
	input logic intclk,
	input logic arst_n,
	result_bus_if.store engine,
	result_bus_if.store host
);
	import corr_pkg::*;

	count_t mem [mem_words];
	logic [mem_words-1:0] written;

	assign engine.gnt = engine.req;
	assign host.gnt = host.req && !engine.req;

	always_ff @(posedge intclk) begin
		if (engine.gnt && engine.we)
			mem[engine.addr] <= engine.wdata;
		if (host.gnt && host.we)
			mem[host.addr] <= host.wdata;
		engine.rdata <= written[engine.addr] ? mem[engine.addr] : '0;
		host.rdata <= written[host.addr] ? mem[host.addr] : '0;
	end

	// Words that were never written read back as zero.
	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			written <= '0;
			engine.rvalid <= 1'b0;
			host.rvalid <= 1'b0;
		end else begin
			if (engine.gnt && engine.we)
				written[engine.addr] <= 1'b1;
			if (host.gnt && host.we)
				written[host.addr] <= 1'b1;
			engine.rvalid <= engine.gnt && !engine.we;
			host.rvalid <= host.gnt && !host.we;
		end
	end

endmodule

`default_nettype wire

//--- rtl/corr_engine.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Correlation engine: counts line agreements over one
// window, then writes every count into the result store.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module corr_engine (
	input logic intclk,
	input logic arst_n,
	input corr_pkg::sample_t line_in,
	input logic sample_valid,
	input logic start,
	input corr_pkg::count_t integ_len,
	output logic busy,
	output logic done,
	result_bus_if.requester store
);
	import corr_pkg::*;

	engine_state_t state;
	logic done_q;
	logic take;
	res_addr_t dump_idx;
	count_t sample_cnt;
	count_t auto_cnt [num_inputs][num_lags];
	count_t cross_cnt [num_pairs][num_lags];
	count_t results [num_results];
	sample_t taps [num_lags];
	sample_t hist [num_lags+1];

	assign take = (state == st_integrate) && sample_valid;

	lag_delay_line u_delay (
		.intclk(intclk),
		.arst_n(arst_n),
		.clear(start),
		.shift(take),
		.sample(line_in),
		.taps(taps)
	);

	// hist[k] is the sample k valid samples back; hist[0] is the present one.
	always_comb begin
		hist[0] = line_in;
		for (int k = 0; k < num_lags; k++) begin
			hist[k+1] = taps[k];
		end
	end

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Agreement counters
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			sample_cnt <= '0;
			auto_cnt <= '{default: '0};
			cross_cnt <= '{default: '0};
		end else if (start) begin
			sample_cnt <= '0;
			auto_cnt <= '{default: '0};
			cross_cnt <= '{default: '0};
		end else if (take) begin
			sample_cnt <= sample_cnt + 1'b1;
			for (int a = 0; a < num_inputs; a++) begin
				for (int k = 0; k < num_lags; k++) begin
					if (line_in[a] == hist[k+1][a])
						auto_cnt[a][k] <= auto_cnt[a][k] + 1'b1;
				end
			end
			// Cross lags run 0 to 3, so they start at the present sample.
			for (int p = 0; p < num_pairs; p++) begin
				for (int k = 0; k < num_lags; k++) begin
					if (line_in[pair_first[p]] == hist[k][pair_second[p]])
						cross_cnt[p][k] <= cross_cnt[p][k] + 1'b1;
				end
			end
		end
	end

	always_comb begin
		results[0] = sample_cnt;
		for (int a = 0; a < num_inputs; a++) begin
			for (int k = 0; k < num_lags; k++) begin
				results[auto_base + num_lags*a + k] = auto_cnt[a][k];
			end
		end
		for (int p = 0; p < num_pairs; p++) begin
			for (int k = 0; k < num_lags; k++) begin
				results[cross_base + num_lags*p + k] = cross_cnt[p][k];
			end
		end
	end

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Window control and dump
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			dump_idx <= '0;
			done_q <= 1'b0;
		end else begin
			case (state)
				st_idle: if (start) begin
					state <= st_integrate;
					dump_idx <= '0;
					done_q <= 1'b0;
				end
				st_integrate: if (take && count_t'(sample_cnt + 1'b1) == integ_len)
					state <= st_dump;
				default: if (store.gnt) begin
					if (dump_idx == res_addr_t'(num_results - 1)) begin
						state <= st_idle;
						done_q <= 1'b1;
					end else begin
						dump_idx <= dump_idx + 1'b1;
					end
				end
			endcase
		end
	end

	// The start cycle already reports busy so a second start is refused.
	assign busy = (state != st_idle) || start;
	assign done = done_q && !start;

	assign store.req = (state == st_dump);
	assign store.we = 1'b1;
	assign store.addr = dump_idx;
	assign store.wdata = results[dump_idx];

endmodule

`default_nettype wire

//--- rtl/lag_delay_line.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lag history: the last few valid samples of every line,
// cleared at the start of each integration window.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module lag_delay_line (
	input logic intclk,
	input logic arst_n,
	input logic clear,
	input logic shift,
	input corr_pkg::sample_t sample,
	output corr_pkg::sample_t taps [corr_pkg::num_lags]
);
	import corr_pkg::*;

	// Tap k holds the sample taken k+1 valid samples ago.
	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			taps <= '{default: '0};
		end else if (clear) begin
			taps <= '{default: '0};
		end else if (shift) begin
			taps[0] <= sample;
			for (int k = 1; k < num_lags; k++) begin
				taps[k] <= taps[k-1];
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/result_bus_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result memory port: one requester against the store.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface result_bus_if;
	import corr_pkg::*;

	logic req;
	logic we;
	res_addr_t addr;
	count_t wdata;
	logic gnt;
	count_t rdata;
	logic rvalid;

	// Request fields stay put until gnt; read data comes one cycle after gnt.
	modport requester (output req, we, addr, wdata, input gnt, rdata, rvalid);
	modport store (input req, we, addr, wdata, output gnt, rdata, rvalid);

endinterface

`default_nettype wire

//--- rtl/corr_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One-bit correlator shared definitions: sizes, types,
// register map and the layout of the result memory.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package corr_pkg;

	localparam int unsigned num_inputs = 4;
	localparam int unsigned num_lags = 4;
	localparam int unsigned num_pairs = 6;
	localparam int unsigned num_results = 41;
	localparam int unsigned mem_words = 64;

	typedef logic [num_inputs-1:0] sample_t;
	typedef logic [15:0] count_t;
	typedef logic [5:0] res_addr_t;
	typedef logic [11:0] axi_addr_t;
	typedef logic [31:0] axi_data_t;

	typedef enum logic [1:0] {st_idle, st_integrate, st_dump} engine_state_t;

	localparam axi_addr_t ctrl_addr = 12'h000;
	localparam axi_addr_t status_addr = 12'h004;
	localparam axi_addr_t result_base = 12'h100;

	// Result layout: word 0 is the sample count, auto counts follow, then cross counts.
	localparam int unsigned auto_base = 1;
	localparam int unsigned cross_base = auto_base + num_inputs * num_lags;

	// Pair p correlates line pair_first[p] against the delayed pair_second[p].
	localparam int unsigned pair_first [num_pairs] = '{0, 0, 0, 1, 1, 2};
	localparam int unsigned pair_second [num_pairs] = '{1, 2, 3, 2, 3, 3};

endpackage

`default_nettype wire
